// ==== vlog.f ====
design/cart_pkg.sv
design/cart_wr_if.sv
design/neo_header_decode.sv
design/rom_region_seq.sv
design/sdram_write_port.sv
design/adpcm_addr_map.sv
design/cart_loader_top.sv
tests/sdram_port_model.sv
tests/cart_loader_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cart_loader_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= vlog.f
VFLAGS    ?= --binary -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/cart_loader_tb.sv ====
`timescale 1ns/1ps

module cart_loader_tb
	import cart_pkg::*;
();

	typedef struct packed {
		logic [7:0]       idx;
		logic [5:0][31:0] sz;
		logic [7:0]       n_bytes;
		logic [7:0]       delay;
		logic [3:0]       a_bank;
		logic [19:0]      a_addr;
		logic [23:0]      b_addr;
		logic [25:0]      exp_a;
		logic [25:0]      exp_b;
	} row_t;

	logic        CLK_48M;
	logic        rst;
	logic        dl_active;
	logic [7:0]  dl_index;
	logic        dl_wr;
	logic [26:0] dl_addr;
	logic [7:0]  dl_data;
	logic        busy;
	logic        cart_loaded;
	logic        p1_req;
	logic        p1_we;
	logic [22:0] p1_a;
	logic [1:0]  p1_ds;
	logic [15:0] p1_d;
	logic        p1_ack;
	logic        p2_req;
	logic        p2_we;
	logic [24:0] p2_a;
	logic [1:0]  p2_ds;
	logic [15:0] p2_d;
	logic        p2_ack;
	logic        a_rd;
	logic [19:0] a_addr;
	logic [3:0]  a_bank;
	logic        b_rd;
	logic [23:0] b_addr;
	logic [25:0] sample_a_addr;
	logic [25:0] sample_b_addr;

	row_t        rows[5];
	logic [26:0] sys_addrs[4];
	int          errors = 0;
	int          checks = 0;
	logic        timed_out = 1'b0;

	cart_loader_top UUT (.*);

	sdram_port_model #(.AW(23)) m1 (
		.CLK_48M(CLK_48M), .rst(rst), .req(p1_req), .we(p1_we),
		.a(p1_a), .ds(p1_ds), .d(p1_d), .ack(p1_ack)
	);

	sdram_port_model #(.AW(25)) m2 (
		.CLK_48M(CLK_48M), .rst(rst), .req(p2_req), .we(p2_we),
		.a(p2_a), .ds(p2_ds), .d(p2_d), .ack(p2_ack)
	);

	always #4 CLK_48M = ~CLK_48M;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < 2000 && !timed_out) begin
			@(negedge CLK_48M);
			n++;
		end
		if (busy && !timed_out) begin
			timed_out = 1'b1;
			errors++;
			$display("Timed out waiting for the loader to go idle");
		end
	endtask

	function automatic logic [18:0] swz_ref(input logic [18:0] a);
		return {a[18:5], a[2:0], ~a[4], a[3]};
	endfunction

	// Reference for the system ROM windows
	function automatic logic [23:0] sys_map(input logic [26:0] a);
		if (a < 27'h08_0000)
			return BASE_SROM + 24'(a[18:0]);
		else if (a < 27'h0A_0000)
			return BASE_LOROM + 24'(a[15:0]);
		else if (a < 27'h0C_0000)
			return BASE_SFIX + 24'(swz_ref({2'b00, a[16:0]}));
		return BASE_SM1 + 24'(a[17:0]);
	endfunction

	// Port 0 means no write is expected
	function automatic void map_cart(input row_t r, input int k, input logic [26:0] dl,
		output int port, output logic [25:0] ba);
		logic [25:0] off;
		int          ri;
		off = 26'(k);
		ri  = 0;
		while (ri < 6 && off >= 26'(r.sz[ri])) begin
			off = off - 26'(r.sz[ri]);
			ri++;
		end
		port = (ri < 3) ? 1 : 2;
		case (ri)
			0: ba = off;
			1: ba = 26'(BASE_FIX + 24'(swz_ref(off[18:0])));
			2: ba = 26'(BASE_MROM + 24'(off[18:0]));
			3: ba = 26'(r.sz[5]) + off;
			4: ba = 26'(r.sz[5] + r.sz[3]) + off;
			default: ba = {off[25:7], dl[5:2], ~dl[6], dl[0], dl[1]};
		endcase
		if ((ri == 3 || ri == 4) && r.idx == IDX_CART_NOPCM)
			port = 0;
	endfunction

	function automatic row_t make_row(input logic [7:0] idx, input int p, input int s,
		input int m, input int v1, input int v2, input int c, input int dly,
		input logic [3:0] bank, input logic [19:0] aa, input logic [23:0] ba,
		input logic [25:0] ea, input logic [25:0] eb);
		row_t r;
		r.idx     = idx;
		r.sz[0]   = p;
		r.sz[1]   = s;
		r.sz[2]   = m;
		r.sz[3]   = v1;
		r.sz[4]   = v2;
		r.sz[5]   = c;
		r.n_bytes = (idx == IDX_BIOS0) ? 8'd4 : 8'(p + s + m + v1 + v2 + c);
		r.delay   = 8'(dly);
		r.a_bank  = bank;
		r.a_addr  = aa;
		r.b_addr  = ba;
		r.exp_a   = ea;
		r.exp_b   = eb;
		return r;
	endfunction

	task automatic send_byte(input logic [26:0] addr, input logic [7:0] data);
		wait_idle();
		if (timed_out)
			return;
		dl_wr   = 1'b1;
		dl_addr = addr;
		dl_data = data;
		@(negedge CLK_48M);
		dl_wr = 1'b0;
	endtask

	task automatic expect_write(input int port, input logic [25:0] ba, input logic [7:0] data);
		logic [41:0] e1;
		logic [43:0] e2;
		check("p1 write count", 32'(m1.log_q.size()), (port == 1) ? 32'd1 : 32'd0);
		check("p2 write count", 32'(m2.log_q.size()), (port == 2) ? 32'd1 : 32'd0);
		if (port == 1 && m1.log_q.size() > 0) begin
			e1 = m1.log_q.pop_front();
			check("p1_a", 32'(e1[22:0]), 32'(ba[23:1]));
			check("p1_d", 32'(e1[38:23]), 32'({data, data}));
			check("p1_ds", 32'(e1[40:39]), 32'({ba[0], ~ba[0]}));
			check("p1_we", 32'(e1[41]), 32'd1);
		end
		if (port == 2 && m2.log_q.size() > 0) begin
			e2 = m2.log_q.pop_front();
			check("p2_a", 32'(e2[24:0]), 32'(ba[25:1]));
			check("p2_d", 32'(e2[40:25]), 32'({data, data}));
			check("p2_ds", 32'(e2[42:41]), 32'({ba[0], ~ba[0]}));
			check("p2_we", 32'(e2[43]), 32'd1);
		end
		m1.log_q.delete();
		m2.log_q.delete();
		check("p1_req", 32'(p1_req), 32'd0);
		check("p2_req", 32'(p2_req), 32'd0);
	endtask

	task automatic run_row(input row_t r);
		logic [26:0] dl;
		logic [7:0]  data;
		logic [25:0] ba;
		int          port;
		int          b;
		m1.max_delay = int'(r.delay);
		m2.max_delay = int'(r.delay);
		@(negedge CLK_48M);
		dl_active = 1'b0;
		@(negedge CLK_48M);
		dl_index  = r.idx;
		dl_active = 1'b1;
		if (r.idx != IDX_BIOS0) begin
			// Header with the six sizes, little endian from byte 4
			for (int a = 0; a < HDR_BYTES && !timed_out; a++) begin
				b    = (a - 4) % 4;
				data = (a >= SIZE_FIRST && a <= SIZE_LAST) ?
					8'(r.sz[(a - 4) / 4] >> (8 * b)) : 8'(a) ^ 8'h5a;
				send_byte(27'(a), data);
			end
			wait_idle();
			if (timed_out)
				return;
			check("cart_loaded", 32'(cart_loaded), 32'd0);
		end
		for (int k = 0; k < int'(r.n_bytes) && !timed_out; k++) begin
			data = 8'(k * 7 + 3);
			dl   = (r.idx == IDX_BIOS0) ? sys_addrs[k] : 27'(HDR_BYTES + k);
			send_byte(dl, data);
			check("busy", 32'(busy), 32'd1);
			wait_idle();
			if (timed_out)
				return;
			if (r.idx == IDX_BIOS0) begin
				expect_write(1, 26'(sys_map(dl)), data);
			end else begin
				map_cart(r, k, dl, port, ba);
				expect_write(port, ba, data);
				check("cart_loaded", 32'(cart_loaded),
					(k == int'(r.n_bytes) - 1) ? 32'd1 : 32'd0);
			end
		end
		if (r.idx != IDX_BIOS0 && !timed_out) begin
			a_bank = r.a_bank;
			a_addr = r.a_addr;
			a_rd   = 1'b1;
			@(negedge CLK_48M);
			check("sample_a_addr", 32'(sample_a_addr), 32'(r.exp_a));
			a_rd   = 1'b0;
			b_addr = r.b_addr;
			b_rd   = 1'b1;
			@(negedge CLK_48M);
			check("sample_b_addr", 32'(sample_b_addr), 32'(r.exp_b));
			b_rd = 1'b0;
		end
	endtask

	initial begin
		CLK_48M   = 1'b0;
		rst       = 1'b1;
		dl_active = 1'b0;
		dl_index  = 8'd0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		a_rd      = 1'b0;
		a_addr    = '0;
		a_bank    = '0;
		b_rd      = 1'b0;
		b_addr    = '0;
		sys_addrs[0] = 27'h00_0123;
		sys_addrs[1] = 27'h08_1234;
		sys_addrs[2] = 27'h0A_0013;
		sys_addrs[3] = 27'h0C_0457;
		// idx, P S M V1 V2 C, ack delay, a bank/addr, b addr, expected a and b
		rows[0] = make_row(IDX_BIOS0, 0, 0, 0, 0, 0, 0, 1, 4'h0, 20'h0, 24'h0, 26'h0, 26'h0);
		rows[1] = make_row(IDX_CART, 8, 8, 4, 6, 4, 16, 3, 4'h1, 20'h00005, 24'h00000E,
			26'h15, 26'h18);
		rows[2] = make_row(IDX_CART, 4, 0, 2, 12, 0, 8, 2, 4'h0, 20'h0000B, 24'h000027,
			26'h13, 26'h0F);
		// Index 2 keeps the sample latches of the row before
		rows[3] = make_row(IDX_CART_NOPCM, 2, 2, 2, 4, 4, 8, 5, 4'h3, 20'h00001, 24'h000002,
			26'h13, 26'h13);
		rows[4] = make_row(IDX_CART, 8, 8, 4, 6, 4, 16, 25, 4'h0, 20'h00003, 24'h000001,
			26'h13, 26'h17);
		repeat (8) @(posedge CLK_48M);
		@(negedge CLK_48M);
		rst = 1'b0;
		check("busy", 32'(busy), 32'd0);
		check("cart_loaded", 32'(cart_loaded), 32'd0);
		check("p1_req", 32'(p1_req), 32'd0);
		check("p2_req", 32'(p2_req), 32'd0);
		for (int i = 0; i < 5 && !timed_out; i++)
			run_row(rows[i]);
		finish_run();
	end

endmodule

// ==== tests/sdram_port_model.sv ====
`timescale 1ns/1ps

module sdram_port_model #(
	parameter int AW = 23
) (
	input  logic          CLK_48M,
	input  logic          rst,
	input  logic          req,
	input  logic          we,
	input  logic [AW-1:0] a,
	input  logic [1:0]    ds,
	input  logic [15:0]   d,
	output logic          ack
);

	// Each entry is {we, ds, d, a}
	logic [AW+18:0] log_q[$];
	int             max_delay = 2;
	integer         seed = 32'h5d94_d79e;
	int             wait_cnt;
	logic           pending;

	initial begin
		ack      <= 1'b0;
		pending  <= 1'b0;
		wait_cnt <= 0;
	end

	// Acts on the falling edge, like the rest of the stimulus
	always @(negedge CLK_48M) begin
		if (rst) begin
			ack     <= 1'b0;
			pending <= 1'b0;
		end else if (ack) begin
			if (!req)
				ack <= 1'b0;
		end else if (req) begin
			if (!pending) begin
				pending  <= 1'b1;
				wait_cnt <= ($random(seed) & 32'h7fff_ffff) % (max_delay + 1);
			end else if (wait_cnt == 0) begin
				ack     <= 1'b1;
				pending <= 1'b0;
				log_q.push_back({we, ds, d, a});
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end
	end

endmodule

// ==== design/cart_loader_top.sv ====
`timescale 1ns/1ps

module cart_loader_top
	import cart_pkg::*;
(
	input  logic                 CLK_48M,
	input  logic                 rst,

	input  logic                 dl_active,
	input  logic [7:0]           dl_index,
	input  logic                 dl_wr,
	input  logic [26:0]          dl_addr,
	input  logic [7:0]           dl_data,

	output logic                 busy,
	output logic                 cart_loaded,

	output logic                 p1_req,
	output logic                 p1_we,
	output logic [P1_AW-2:0]     p1_a,
	output logic [1:0]           p1_ds,
	output logic [15:0]          p1_d,
	input  logic                 p1_ack,

	output logic                 p2_req,
	output logic                 p2_we,
	output logic [P2_AW-2:0]     p2_a,
	output logic [1:0]           p2_ds,
	output logic [15:0]          p2_d,
	input  logic                 p2_ack,

	input  logic                 a_rd,
	input  logic [19:0]          a_addr,
	input  logic [3:0]           a_bank,
	input  logic                 b_rd,
	input  logic [23:0]          b_addr,
	output logic [SAMPLE_AW-1:0] sample_a_addr,
	output logic [SAMPLE_AW-1:0] sample_b_addr
);

	cart_info_t info;
	logic       hdr_done;

	cart_wr_if #(.addr_t(logic [P1_AW-1:0])) p1_if ();
	cart_wr_if #(.addr_t(logic [P2_AW-1:0])) p2_if ();

	neo_header_decode u_hdr (
		.CLK_48M   (CLK_48M),
		.rst       (rst),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.info      (info),
		.hdr_done  (hdr_done)
	);

	rom_region_seq u_seq (
		.CLK_48M     (CLK_48M),
		.rst         (rst),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.info        (info),
		.hdr_done    (hdr_done),
		.p1          (p1_if.seq),
		.p2          (p2_if.seq),
		.busy        (busy),
		.cart_loaded (cart_loaded)
	);

	sdram_write_port #(.addr_t(logic [P1_AW-1:0])) p1_wr (
		.CLK_48M (CLK_48M),
		.rst     (rst),
		.wr      (p1_if.port),
		.sd_req  (p1_req),
		.sd_we   (p1_we),
		.sd_a    (p1_a),
		.sd_ds   (p1_ds),
		.sd_d    (p1_d),
		.sd_ack  (p1_ack)
	);

	sdram_write_port #(.addr_t(logic [P2_AW-1:0])) p2_wr (
		.CLK_48M (CLK_48M),
		.rst     (rst),
		.wr      (p2_if.port),
		.sd_req  (p2_req),
		.sd_we   (p2_we),
		.sd_a    (p2_a),
		.sd_ds   (p2_ds),
		.sd_d    (p2_d),
		.sd_ack  (p2_ack)
	);

	adpcm_addr_map u_adpcm (
		.CLK_48M       (CLK_48M),
		.rst           (rst),
		.info          (info),
		.a_rd          (a_rd),
		.a_addr        (a_addr),
		.a_bank        (a_bank),
		.b_rd          (b_rd),
		.b_addr        (b_addr),
		.sample_a_addr (sample_a_addr),
		.sample_b_addr (sample_b_addr)
	);

endmodule

// ==== design/adpcm_addr_map.sv ====
`timescale 1ns/1ps

module adpcm_addr_map
	import cart_pkg::*;
(
	input  logic                 CLK_48M,
	input  logic                 rst,
	input  cart_info_t           info,
	input  logic                 a_rd,
	input  logic [19:0]          a_addr,
	input  logic [3:0]           a_bank,
	input  logic                 b_rd,
	input  logic [23:0]          b_addr,
	output logic [SAMPLE_AW-1:0] sample_a_addr,
	output logic [SAMPLE_AW-1:0] sample_b_addr
);

	logic                 a_rd_q;
	logic                 b_rd_q;
	logic [SAMPLE_AW-1:0] a_lat;
	logic [SAMPLE_AW-1:0] b_lat;
	logic [SAMPLE_AW-1:0] b_mask;
	logic [SAMPLE_AW-1:0] b_base;

	assign b_mask = info.pcm_merged ? info.v1_mask : info.v2_mask;

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			a_rd_q <= 1'b0;
			b_rd_q <= 1'b0;
			a_lat  <= '0;
			b_lat  <= '0;
		end else begin
			a_rd_q <= a_rd;
			b_rd_q <= b_rd;
			if (a_rd && !a_rd_q && info.adpcm_en)
				a_lat <= SAMPLE_AW'({a_bank, a_addr}) & info.v1_mask;
			if (b_rd && !b_rd_q && info.adpcm_en)
				b_lat <= SAMPLE_AW'(b_addr) & b_mask;
		end
	end

	// Sample area sits right after C ROM, V1 then V2
	always_comb begin
		if (info.pcm_merged)
			b_base = SAMPLE_AW'(info.c_size);
		else
			b_base = SAMPLE_AW'(info.c_size + info.v1_size);
	end

	assign sample_a_addr = SAMPLE_AW'(info.c_size) + a_lat;
	assign sample_b_addr = b_base + b_lat;

endmodule

// ==== design/sdram_write_port.sv ====
`timescale 1ns/1ps

module sdram_write_port
	import cart_pkg::*;
#(
	parameter type addr_t = logic [P1_AW-1:0]
) (
	input  logic                     CLK_48M,
	input  logic                     rst,
	cart_wr_if.port                  wr,
	output logic                     sd_req,
	output logic                     sd_we,
	output logic [$bits(addr_t)-2:0] sd_a,
	output logic [1:0]               sd_ds,
	output logic [15:0]              sd_d,
	input  logic                     sd_ack
);

	typedef enum logic [1:0] {
		PS_IDLE,
		PS_REQ,
		PS_DRAIN,
		PS_ACK
	} pstate_t;

	pstate_t    state;
	addr_t      lat_addr;
	logic [7:0] lat_data;

	always_ff @(posedge CLK_48M) begin
		if (state == PS_IDLE && wr.req) begin
			lat_addr <= wr.addr;
			lat_data <= wr.data;
		end
	end

	// SDRAM side closes fully before the sequencer sees ack
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			state  <= PS_IDLE;
			sd_req <= 1'b0;
			wr.ack <= 1'b0;
		end else begin
			case (state)
				PS_IDLE: begin
					if (wr.req) begin
						sd_req <= 1'b1;
						state  <= PS_REQ;
					end
				end
				PS_REQ: begin
					if (sd_ack) begin
						sd_req <= 1'b0;
						state  <= PS_DRAIN;
					end
				end
				PS_DRAIN: begin
					if (!sd_ack) begin
						wr.ack <= 1'b1;
						state  <= PS_ACK;
					end
				end
				default: begin
					if (!wr.req) begin
						wr.ack <= 1'b0;
						state  <= PS_IDLE;
					end
				end
			endcase
		end
	end

	// Byte lane picked by address bit 0
	assign sd_we = sd_req;
	assign sd_a  = lat_addr[$bits(addr_t)-1:1];
	assign sd_ds = {lat_addr[0], ~lat_addr[0]};
	assign sd_d  = {lat_data, lat_data};

endmodule

// ==== design/rom_region_seq.sv ====
`timescale 1ns/1ps

module rom_region_seq
	import cart_pkg::*;
(
	input  logic          CLK_48M,
	input  logic          rst,
	input  logic          dl_active,
	input  logic [7:0]    dl_index,
	input  logic          dl_wr,
	input  logic [26:0]   dl_addr,
	input  logic [7:0]    dl_data,
	input  cart_info_t    info,
	input  logic          hdr_done,
	cart_wr_if.seq        p1,
	cart_wr_if.seq        p2,
	output logic          busy,
	output logic          cart_loaded
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WR,
		ST_REL,
		ST_ADV
	} state_t;

	state_t           state;
	region_t          region;
	logic [P2_AW-1:0] offset;
	logic [P2_AW-1:0] region_size;
	logic             to_p2;
	logic             sys_mode;
	logic             dl_active_q;
	logic             sys_wr;
	logic             cart_wr;
	logic             skip_pcm;
	logic             on_p1;
	logic             cur_ack;
	logic [P1_AW-1:0] sys_addr;
	logic [P1_AW-1:0] cart_p1_addr;
	logic [P2_AW-1:0] cart_p2_addr;

	// FIX tile byte order
	function automatic logic [18:0] fix_swz(input logic [18:0] a);
		return {a[18:5], a[2:0], ~a[4], a[3]};
	endfunction

	assign sys_wr   = dl_active && dl_wr && (dl_index == IDX_BIOS0 || dl_index == IDX_BIOS3);
	assign cart_wr  = dl_active && dl_wr && (dl_index == IDX_CART || dl_index == IDX_CART_NOPCM)
		&& (dl_addr >= 27'(HDR_BYTES)) && (region != REG_DONE);
	assign skip_pcm = (dl_index == IDX_CART_NOPCM) && (region == REG_V1 || region == REG_V2);
	assign on_p1    = (region == REG_P) || (region == REG_S) || (region == REG_M);
	assign cur_ack  = to_p2 ? p2.ack : p1.ack;
	assign busy     = (state != ST_IDLE) || hdr_done;

	always_comb begin
		case (region)
			REG_P:   region_size = info.p_size[P2_AW-1:0];
			REG_S:   region_size = info.s_size[P2_AW-1:0];
			REG_M:   region_size = info.m_size[P2_AW-1:0];
			REG_V1:  region_size = info.v1_size[P2_AW-1:0];
			REG_V2:  region_size = info.v2_size[P2_AW-1:0];
			REG_C:   region_size = info.c_size[P2_AW-1:0];
			default: region_size = '0;
		endcase
	end

	// System ROM windows
	always_comb begin
		if (dl_addr[23:19] == 5'd0)
			sys_addr = BASE_SROM + P1_AW'(dl_addr[18:0]);
		else if (dl_addr[23:17] == 7'b000_0100)
			sys_addr = BASE_LOROM + P1_AW'(dl_addr[15:0]);
		else if (dl_addr[23:17] == 7'b000_0101)
			sys_addr = BASE_SFIX + P1_AW'(fix_swz({2'b00, dl_addr[16:0]}));
		else
			sys_addr = BASE_SM1 + P1_AW'(dl_addr[17:0]);
	end

	always_comb begin
		case (region)
			REG_S:   cart_p1_addr = BASE_FIX + P1_AW'(fix_swz(offset[18:0]));
			REG_M:   cart_p1_addr = BASE_MROM + P1_AW'(offset[18:0]);
			default: cart_p1_addr = offset[P1_AW-1:0];
		endcase
		case (region)
			REG_V1:  cart_p2_addr = P2_AW'(info.c_size) + offset;
			REG_V2:  cart_p2_addr = P2_AW'(info.c_size + info.v1_size) + offset;
			// C ROM planes are interleaved within each 128 byte block
			default: cart_p2_addr = {offset[P2_AW-1:7], dl_addr[5:2], ~dl_addr[6],
				dl_addr[0], dl_addr[1]};
		endcase
	end

	always_ff @(posedge CLK_48M) begin
		if (state == ST_IDLE && !hdr_done && (sys_wr || cart_wr)) begin
			p1.addr <= sys_wr ? sys_addr : cart_p1_addr;
			p1.data <= dl_data;
			p2.addr <= cart_p2_addr;
			p2.data <= dl_data;
		end
	end

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			state       <= ST_IDLE;
			region      <= REG_DONE;
			offset      <= '0;
			to_p2       <= 1'b0;
			sys_mode    <= 1'b0;
			p1.req      <= 1'b0;
			p2.req      <= 1'b0;
			cart_loaded <= 1'b0;
			dl_active_q <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			if (dl_active && !dl_active_q)
				cart_loaded <= 1'b0;

			case (state)
				ST_IDLE: begin
					if (hdr_done) begin
						// Leading empty regions get skipped right away
						region <= REG_P;
						offset <= '0;
						state  <= ST_ADV;
					end else if (sys_wr) begin
						p1.req   <= 1'b1;
						to_p2    <= 1'b0;
						sys_mode <= 1'b1;
						state    <= ST_WR;
					end else if (cart_wr) begin
						sys_mode <= 1'b0;
						if (skip_pcm) begin
							offset <= offset + P2_AW'(1);
							state  <= ST_ADV;
						end else if (on_p1) begin
							p1.req <= 1'b1;
							to_p2  <= 1'b0;
							state  <= ST_WR;
						end else begin
							p2.req <= 1'b1;
							to_p2  <= 1'b1;
							state  <= ST_WR;
						end
					end
				end
				ST_WR: begin
					if (cur_ack) begin
						p1.req <= 1'b0;
						p2.req <= 1'b0;
						state  <= ST_REL;
					end
				end
				ST_REL: begin
					if (!cur_ack) begin
						if (sys_mode) begin
							state <= ST_IDLE;
						end else begin
							offset <= offset + P2_AW'(1);
							state  <= ST_ADV;
						end
					end
				end
				ST_ADV: begin
					// One region per cycle until one still has room
					if (region != REG_DONE && offset == region_size) begin
						offset <= '0;
						region <= region_t'(region + 3'd1);
						if (region == REG_C)
							cart_loaded <= 1'b1;
					end else begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== design/neo_header_decode.sv ====
`timescale 1ns/1ps

module neo_header_decode
	import cart_pkg::*;
(
	input  logic        CLK_48M,
	input  logic        rst,
	input  logic        dl_active,
	input  logic [7:0]  dl_index,
	input  logic        dl_wr,
	input  logic [26:0] dl_addr,
	input  logic [7:0]  dl_data,
	output cart_info_t  info,
	output logic        hdr_done
);

	logic is_cart;
	logic hdr_wr;
	logic size_byte;
	logic last_byte;

	assign is_cart   = (dl_index == IDX_CART) || (dl_index == IDX_CART_NOPCM);
	assign hdr_wr    = dl_active && dl_wr && is_cart && (dl_addr < 27'(HDR_BYTES));
	assign size_byte = (dl_addr >= 27'(SIZE_FIRST)) && (dl_addr <= 27'(SIZE_LAST));
	assign last_byte = dl_addr == 27'(HDR_BYTES - 1);

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			info     <= '0;
			hdr_done <= 1'b0;
		end else begin
			hdr_done <= 1'b0;

			// Six LE words enter at the top of C size and ripple down to P size
			if (hdr_wr && size_byte) begin
				info.c_size  <= {dl_data, info.c_size[31:8]};
				info.v2_size <= {info.c_size[7:0], info.v2_size[31:8]};
				info.v1_size <= {info.v2_size[7:0], info.v1_size[31:8]};
				info.m_size  <= {info.v1_size[7:0], info.m_size[31:8]};
				info.s_size  <= {info.m_size[7:0], info.s_size[31:8]};
				info.p_size  <= {info.s_size[7:0], info.p_size[31:8]};
			end

			if (hdr_wr && last_byte) begin
				info.v1_mask <= SAMPLE_AW'(ceil_mask(info.v1_size));
				info.v2_mask <= SAMPLE_AW'(ceil_mask(info.v2_size));
				// Neobuilder files put ADPCM-B inside V1 and leave V2 empty
				info.pcm_merged <= info.v2_size == 32'd0;
				info.adpcm_en   <= dl_index != IDX_CART_NOPCM;
				hdr_done        <= 1'b1;
			end
		end
	end

endmodule

// ==== design/cart_wr_if.sv ====
`timescale 1ns/1ps

interface cart_wr_if
	import cart_pkg::*;
#(
	parameter type addr_t = logic [P1_AW-1:0]
) ();

	logic       req;
	logic       ack;
	addr_t      addr;
	logic [7:0] data;

	modport seq (
		output req,
		output addr,
		output data,
		input  ack
	);

	modport port (
		input  req,
		input  addr,
		input  data,
		output ack
	);

endinterface

// ==== design/cart_pkg.sv ====
package cart_pkg;

	// Cartridge file layout
	localparam int HDR_BYTES  = 4096;
	localparam int SIZE_FIRST = 4;
	localparam int SIZE_LAST  = 27;

	// Download index codes
	localparam logic [7:0] IDX_BIOS0      = 8'd0;
	localparam logic [7:0] IDX_CART       = 8'd1;
	localparam logic [7:0] IDX_CART_NOPCM = 8'd2;
	localparam logic [7:0] IDX_BIOS3      = 8'd3;

	// Port 1 bank bases
	localparam logic [23:0] BASE_SROM  = 24'hF8_0000;
	localparam logic [23:0] BASE_LOROM = 24'hDE_0000;
	localparam logic [23:0] BASE_SFIX  = 24'hE8_0000;
	localparam logic [23:0] BASE_SM1   = 24'hEC_0000;
	localparam logic [23:0] BASE_FIX   = 24'hE0_0000;
	localparam logic [23:0] BASE_MROM  = 24'hF0_0000;

	localparam int P1_AW     = 24;
	localparam int P2_AW     = 26;
	localparam int SAMPLE_AW = 26;

	typedef enum logic [2:0] {
		REG_P,
		REG_S,
		REG_M,
		REG_V1,
		REG_V2,
		REG_C,
		REG_DONE
	} region_t;

	typedef struct packed {
		logic [31:0]          p_size;
		logic [31:0]          s_size;
		logic [31:0]          m_size;
		logic [31:0]          v1_size;
		logic [31:0]          v2_size;
		logic [31:0]          c_size;
		logic [SAMPLE_AW-1:0] v1_mask;
		logic [SAMPLE_AW-1:0] v2_mask;
		logic                 pcm_merged;
		logic                 adpcm_en;
	} cart_info_t;

	// Next power of two at or above value, minus one
	function automatic logic [31:0] ceil_mask(input logic [31:0] value);
		logic [31:0] m;
		m = value - 32'd1;
		for (int k = 0; k < 5; k++) begin
			m = m | (m >> (1 << k));
		end
		return (value == 32'd0) ? 32'd0 : m;
	endfunction

endpackage
